/* project.f */
rtl/cart_pkg.sv
rtl/rom_write_pacer.sv
rtl/header_region_scan.sv
rtl/cart_quirk_lookup.sv
rtl/region_select.sv
rtl/cart_loader_top.sv
test/cart_loader_props.sv
test/cart_loader_tb.sv

/* test/cart_loader_tb.sv */
`timescale 1ns/100ps

module cart_loader_tb;

	logic                 clk_sys = 1'b0;
	logic                 RESET;
	logic                 cart_download;
	logic                 ioctl_wr;
	cart_pkg::addr_t      ioctl_addr;
	cart_pkg::word_t      ioctl_data;
	logic [7:0]           ioctl_index;
	logic [1:0]           region_mode;
	logic [1:0]           region_priority;
	logic                 mem_ack_a;
	logic                 mem_ack_b;
	logic                 rom_wr;
	logic                 ioctl_wait;
	cart_pkg::addr_t      rom_size;
	cart_pkg::quirk_t     quirks;
	logic                 gun_type;
	cart_pkg::gun_delay_t gun_delay;
	cart_pkg::region_t    region_req;
	logic                 region_set;

	integer seed = 32'h4f;
	int     error_count = 0;
	int     busy_a;
	int     busy_b;
	int     dly_a;
	int     dly_b;

	// Image table with one entry per cartridge
	logic [23:0] t_region [$]; // Three header region letters
	logic [63:0] t_code   [$];
	logic [1:0]  t_mode   [$];
	logic [1:0]  t_prio   [$];
	logic [7:0]  t_index  [$];
	logic [1:0]  t_req    [$];
	logic        t_set    [$];
	logic [5:0]  t_quirks [$];
	logic        t_gun    [$];
	logic [7:0]  t_delay  [$];

	always #50 clk_sys = ~clk_sys;

	cart_loader_top cart_loader_top_i (.*);

	bind rom_write_pacer cart_loader_props pacer_props_i (
		.clk_sys(clk_sys), .RESET(RESET), .cart_download(cart_download),
		.ioctl_wr(ioctl_wr), .rom_wr(rom_wr), .ioctl_wait(ioctl_wait), .state(state),
		.hdr_ready(1'b1), .region_set(1'b0)
	);

	bind region_select cart_loader_props region_props_i (
		.clk_sys(clk_sys), .RESET(RESET), .cart_download(1'b0),
		.ioctl_wr(1'b0), .rom_wr(1'b0), .ioctl_wait(1'b0), .state(cart_pkg::PACE_IDLE),
		.hdr_ready(hdr_ready), .region_set(region_set)
	);

	////////////////////////////////////////////////////////////////////////////
	// ROM memories that ack after 0 to 3 extra cycles

	always @(posedge clk_sys) begin
		if (RESET) begin
			mem_ack_a <= 1'b0;
			mem_ack_b <= 1'b0;
			busy_a    <= 0;
			busy_b    <= 0;
		end else begin
			if (!busy_a && mem_ack_a != rom_wr) begin
				busy_a <= 1;
				dly_a  <= $random(seed) & 3;
			end else if (busy_a) begin
				if (dly_a == 0) begin
					mem_ack_a <= rom_wr;
					busy_a    <= 0;
				end else
					dly_a <= dly_a - 1;
			end
			if (!busy_b && mem_ack_b != rom_wr) begin
				busy_b <= 1;
				dly_b  <= $random(seed) & 3;
			end else if (busy_b) begin
				if (dly_b == 0) begin
					mem_ack_b <= rom_wr;
					busy_b    <= 0;
				end else
					dly_b <= dly_b - 1;
			end
		end
	end

	task automatic add_row(input logic [23:0] rg, input logic [63:0] code, input logic [1:0] mode,
		input logic [1:0] prio, input logic [7:0] idx, input logic [1:0] req, input logic set,
		input logic [5:0] q, input logic gun, input logic [7:0] dly);
		t_region.push_back(rg);
		t_code.push_back(code);
		t_mode.push_back(mode);
		t_prio.push_back(prio);
		t_index.push_back(idx);
		t_req.push_back(req);
		t_set.push_back(set);
		t_quirks.push_back(q);
		t_gun.push_back(gun);
		t_delay.push_back(dly);
	endtask

	task automatic compare_value(input string what, input logic [63:0] got,
		input logic [63:0] exp);
		assert (got === exp) else begin
			$display("[ERROR] %0t: %s is 'h%0h, expected 'h%0h", $time, what, got, exp);
			error_count++;
		end
	endtask

	// Value checks plus failures of the bound assertions
	function automatic int error_total();
		return error_count + cart_loader_top_i.rom_write_pacer_i.pacer_props_i.fail_count
			+ cart_loader_top_i.region_select_i.region_props_i.fail_count;
	endfunction

	task automatic give_up(input string why);
		$display("Timeout: %s", why);
		$display("Test failed");
		$finish;
	endtask

	// File byte of one image with the code at 'h183 to 'h18A
	function automatic logic [7:0] byte_at(input cart_pkg::addr_t a, input int r);
		logic [7:0] b;
		b = 8'h00;
		if (a > cart_pkg::ID_ADDR_FIRST && a <= cart_pkg::ID_ADDR_LAST)
			b = t_code[r][8*(cart_pkg::ID_ADDR_LAST - a) +: 8];
		else if (a == cart_pkg::HDR_REGION_A)
			b = t_region[r][23:16];
		else if (a == cart_pkg::HDR_REGION_A + 25'd1)
			b = t_region[r][15:8];
		else if (a == cart_pkg::HDR_REGION_B)
			b = t_region[r][7:0];
		else if (a == cart_pkg::HDR_REGION_B + 25'd1)
			b = "J"; // Not a region byte and must be ignored
		return b;
	endfunction

	task automatic send_word(input cart_pkg::addr_t a, input int r);
		int n;
		@(posedge clk_sys);
		ioctl_wr   <= 1'b1;
		ioctl_addr <= a;
		ioctl_data <= {byte_at(a + 25'd1, r), byte_at(a, r)};
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
		n = 0;
		@(negedge clk_sys);
		while (ioctl_wait) begin
			if (n == 40)
				give_up($sformatf("ioctl_wait stuck high after word at 'h%0h", a));
			n++;
			@(negedge clk_sys);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// One full download and its checks

	task automatic run_image(input int r, inout int failed);
		int errs_before;
		errs_before = error_total();
		@(posedge clk_sys);
		cart_download   <= 1'b1;
		region_mode     <= t_mode[r];
		region_priority <= t_prio[r];
		ioctl_index     <= t_index[r];
		@(posedge clk_sys);
		@(negedge clk_sys);
		compare_value("quirks at start", quirks, 0);
		compare_value("header flags at start", {cart_loader_top_i.hdr_j,
			cart_loader_top_i.hdr_u, cart_loader_top_i.hdr_e}, 0);
		for (int a = 0; a <= 'h20E; a += 2)
			send_word(a, r);
		if (t_mode[r] == cart_pkg::MODE_HEADER || t_mode[r] == cart_pkg::MODE_FILE_EXT)
			compare_value("region_req", region_req, t_req[r]);
		compare_value("region_set", region_set, t_set[r]);
		compare_value("quirks", quirks, t_quirks[r]);
		compare_value("gun_type", gun_type, t_gun[r]);
		compare_value("gun_delay", gun_delay, t_delay[r]);
		@(posedge clk_sys);
		cart_download <= 1'b0;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		compare_value("rom_size", rom_size, 'h20E);
		compare_value("region_set after download", region_set, 0);
		if (error_total() == errs_before)
			$display("Image %0d (%s): ok", r, t_code[r]);
		else begin
			$display("Image %0d (%s): FAILED", r, t_code[r]);
			failed++;
		end
	endtask

	initial begin
		int failed;
		failed          = 0;
		RESET           = 1'b1;
		cart_download   = 1'b0;
		ioctl_wr        = 1'b0;
		ioctl_addr      = '0;
		ioctl_data      = '0;
		ioctl_index     = 8'h00;
		region_mode     = 2'd0;
		region_priority = 2'd0;
		mem_ack_a       = 1'b0;
		mem_ack_b       = 1'b0;

		// Region, code, mode, prio, index, req, set, quirks, gun, delay
		add_row("J  ", "T-081276", 2'd2, 2'd0, 8'h00, 2'd0, 1'b1, 6'b000001, 1'b0, 8'd44);
		add_row("UE ", "MK-1215 ", 2'd2, 2'd1, 8'h00, 2'd2, 1'b1, 6'b000010, 1'b0, 8'd44);
		add_row("   ", "T-89016 ", 2'd2, 2'd3, 8'h00, 2'd0, 1'b1, 6'b000100, 1'b0, 8'd44);
		add_row("JUE", "MK-1229 ", 2'd2, 2'd2, 8'h00, 2'd1, 1'b1, 6'b001000, 1'b0, 8'd44);
		add_row("JUE", "T-25073 ", 2'd2, 2'd1, 8'h00, 2'd2, 1'b1, 6'b010000, 1'b0, 8'd44);
		add_row("J4 ", "T-113016", 2'd2, 2'd0, 8'h00, 2'd2, 1'b1, 6'b100000, 1'b0, 8'd44);
		add_row("J  ", "MK-1533 ", 2'd1, 2'd0, 8'h81, 2'd2, 1'b1, 6'b000000, 1'b0, 8'd100);
		add_row("J  ", "T-95096-", 2'd1, 2'd0, 8'h00, 2'd0, 1'b0, 6'b000000, 1'b1, 8'd52);
		add_row("E  ", "T-95136-", 2'd1, 2'd0, 8'h45, 2'd1, 1'b1, 6'b000000, 1'b1, 8'd30);
		add_row("U  ", "MK-1658 ", 2'd3, 2'd0, 8'hFF, 2'd0, 1'b0, 6'b000000, 1'b0, 8'd120);
		add_row("U  ", "T-081156", 2'd0, 2'd0, 8'hFF, 2'd0, 1'b0, 6'b000000, 1'b0, 8'd126);
		add_row("E  ", "GM-99999", 2'd2, 2'd0, 8'h00, 2'd2, 1'b1, 6'b000000, 1'b0, 8'd44);
		add_row("U  ", "G-4060  ", 2'd2, 2'd3, 8'h00, 2'd1, 1'b1, 6'b000010, 1'b0, 8'd44);

		repeat (10) @(posedge clk_sys);
		RESET <= 1'b0;

		for (int r = 0; r < t_code.size(); r++)
			run_image(r, failed);

		$display("%0d images run, %0d failed, %0d errors", t_code.size(), failed,
			error_total());
		if (error_total() == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* test/cart_loader_props.sv */
`timescale 1ns/100ps

module cart_loader_props (
	input logic                   clk_sys,
	input logic                   RESET,
	input logic                   cart_download,
	input logic                   ioctl_wr,
	input logic                   rom_wr,
	input logic                   ioctl_wait,
	input cart_pkg::pacer_state_e state,
	input logic                   hdr_ready,
	input logic                   region_set
);

	logic word_stb;
	int   fail_count = 0;

	assign word_stb = cart_download & ioctl_wr;

	////////////////////////////////////////////////////////////////////////////
	// Pacer handshake

	// Every accepted word flips the request level
	toggle_per_word: assert property (@(posedge clk_sys) disable iff (RESET)
		word_stb |=> (rom_wr != $past(rom_wr)))
		else begin
			$error("rom_wr did not toggle after a word strobe");
			fail_count++;
		end

	hold_after_word: assert property (@(posedge clk_sys) disable iff (RESET)
		word_stb |=> (ioctl_wait && state == cart_pkg::PACE_WAIT))
		else begin
			$error("ioctl_wait not high in the cycle after a word strobe");
			fail_count++;
		end

	////////////////////////////////////////////////////////////////////////////
	// Region set only while the header is ready

	set_needs_ready: assert property (@(posedge clk_sys) disable iff (RESET)
		!hdr_ready |=> !region_set)
		else begin
			$error("region_set high while hdr_ready is low");
			fail_count++;
		end

endmodule

/* rtl/cart_loader_top.sv */
`timescale 1ns/100ps

module cart_loader_top (
	input  logic                  clk_sys,
	input  logic                  RESET,
	input  logic                  cart_download,
	input  logic                  ioctl_wr,
	input  cart_pkg::addr_t       ioctl_addr,
	input  cart_pkg::word_t       ioctl_data,
	input  logic [7:0]            ioctl_index,
	input  logic [1:0]            region_mode,
	input  logic [1:0]            region_priority,
	input  logic                  mem_ack_a,
	input  logic                  mem_ack_b,
	output logic                  rom_wr,
	output logic                  ioctl_wait,
	output cart_pkg::addr_t       rom_size,
	output cart_pkg::quirk_t      quirks,
	output logic                  gun_type,
	output cart_pkg::gun_delay_t  gun_delay,
	output cart_pkg::region_t     region_req,
	output logic                  region_set
);

	logic hdr_j;
	logic hdr_u;
	logic hdr_e;
	logic hdr_ready;

	////////////////////////////////////////////////////////////////////////////
	// Download stream forks into pacer and both scans

	rom_write_pacer rom_write_pacer_i (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.cart_download (cart_download),
		.ioctl_wr      (ioctl_wr),
		.ioctl_addr    (ioctl_addr),
		.mem_ack_a     (mem_ack_a),
		.mem_ack_b     (mem_ack_b),
		.rom_wr        (rom_wr),
		.ioctl_wait    (ioctl_wait),
		.rom_size      (rom_size)
	);

	header_region_scan header_region_scan_i (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.cart_download (cart_download),
		.ioctl_wr      (ioctl_wr),
		.ioctl_addr    (ioctl_addr),
		.ioctl_data    (ioctl_data),
		.hdr_j         (hdr_j),
		.hdr_u         (hdr_u),
		.hdr_e         (hdr_e),
		.hdr_ready     (hdr_ready)
	);

	cart_quirk_lookup cart_quirk_lookup_i (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.cart_download (cart_download),
		.ioctl_wr      (ioctl_wr),
		.ioctl_addr    (ioctl_addr),
		.ioctl_data    (ioctl_data),
		.quirks        (quirks),
		.gun_type      (gun_type),
		.gun_delay     (gun_delay)
	);

	// Header flags feed the region decision
	region_select region_select_i (
		.clk_sys         (clk_sys),
		.RESET           (RESET),
		.hdr_j           (hdr_j),
		.hdr_u           (hdr_u),
		.hdr_e           (hdr_e),
		.hdr_ready       (hdr_ready),
		.region_mode     (region_mode),
		.region_priority (region_priority),
		.ioctl_index     (ioctl_index),
		.region_req      (region_req),
		.region_set      (region_set)
	);

endmodule

/* rtl/region_select.sv */
`timescale 1ns/100ps

module region_select (
	input  logic                clk_sys,
	input  logic                RESET,
	input  logic                hdr_j,
	input  logic                hdr_u,
	input  logic                hdr_e,
	input  logic                hdr_ready,
	input  logic [1:0]          region_mode,
	input  logic [1:0]          region_priority,
	input  logic [7:0]          ioctl_index,
	output cart_pkg::region_t   region_req,
	output logic                region_set
);

	logic              ready_q;
	logic [3:0]        present; // Indexed by region code
	cart_pkg::region_t hdr_pick;

	// First region of the order that the header lists
	function automatic cart_pkg::region_t pick(
		input logic [1:0] prio,
		input logic [3:0] avail
	);
		cart_pkg::region_t order [3];
		cart_pkg::region_t res;
		case (prio)
			cart_pkg::PRIO_US_EU_JP:
				order = '{cart_pkg::REGION_US, cart_pkg::REGION_EU, cart_pkg::REGION_JP};
			cart_pkg::PRIO_EU_US_JP:
				order = '{cart_pkg::REGION_EU, cart_pkg::REGION_US, cart_pkg::REGION_JP};
			cart_pkg::PRIO_US_JP_EU:
				order = '{cart_pkg::REGION_US, cart_pkg::REGION_JP, cart_pkg::REGION_EU};
			default:
				order = '{cart_pkg::REGION_JP, cart_pkg::REGION_US, cart_pkg::REGION_EU};
		endcase
		if (avail[order[0]])
			res = order[0];
		else if (avail[order[1]])
			res = order[1];
		else if (avail[order[2]])
			res = order[2];
		else
			res = order[0]; // Nothing in header, use preferred region
		return res;
	endfunction

	assign present  = {1'b0, hdr_e, hdr_u, hdr_j};
	assign hdr_pick = pick(region_priority, present);

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			ready_q    <= 1'b0;
			region_req <= cart_pkg::REGION_JP;
			region_set <= 1'b0;
		end else begin
			ready_q <= hdr_ready;

			if (hdr_ready && !ready_q) begin
				case (region_mode)
					cart_pkg::MODE_HEADER: begin
						region_req <= hdr_pick;
						region_set <= 1'b1;
					end
					cart_pkg::MODE_FILE_EXT: begin
						region_req <= ioctl_index[7:6];
						region_set <= |ioctl_index;
					end
					default: ; // Disabled, also code 0
				endcase
			end

			if (!hdr_ready && ready_q)
				region_set <= 1'b0;
		end
	end

endmodule

/* rtl/cart_quirk_lookup.sv */
`timescale 1ns/100ps

module cart_quirk_lookup (
	input  logic                  clk_sys,
	input  logic                  RESET,
	input  logic                  cart_download,
	input  logic                  ioctl_wr,
	input  cart_pkg::addr_t       ioctl_addr,
	input  cart_pkg::word_t       ioctl_data,
	output cart_pkg::quirk_t      quirks,
	output logic                  gun_type,
	output cart_pkg::gun_delay_t  gun_delay
);

	logic [63:0]     cart_id; // Eight ASCII characters with the first one on top
	logic [15:0]     data_swap;
	logic            dl_q;
	logic            word_stb;
	cart_pkg::quirk_t quirk_base;

	////////////////////////////////////////////////////////////////////////////
	// Known titles that need special handling

	function automatic cart_pkg::quirk_t quirk_of(input logic [63:0] code);
		cart_pkg::quirk_t q;
		q = '0;
		case (code)
			"T-081276", "T-81406 ":
				q[cart_pkg::Q_SRAM] = 1'b1; // Odd byte SRAM mapping
			"MK-1215 ", "G-4060  ", "T-12046 ":
				q[cart_pkg::Q_EEPROM] = 1'b1; // Serial EEPROM saves
			"T-89016 ":
				q[cart_pkg::Q_FIFO] = 1'b1;
			"MK-1229 ", "G-7001  ":
				q[cart_pkg::Q_SVP] = 1'b1; // DSP cartridge
			"T-35036 ", "T-25073 ", "MK-1137-":
				q[cart_pkg::Q_FMBUSY] = 1'b1;
			"T-113016":
				q[cart_pkg::Q_NORAM] = 1'b1; // Fails on a RAM check otherwise
			default: q = '0;
		endcase
		return q;
	endfunction

	assign data_swap = {ioctl_data[7:0], ioctl_data[15:8]};
	assign word_stb  = cart_download & ioctl_wr;

	assign quirk_base = (cart_download && !dl_q) ? '0 : quirks;

	// Product code capture
	always_ff @(posedge clk_sys) begin
		if (word_stb) begin
			case (ioctl_addr)
				cart_pkg::ID_ADDR_FIRST:          cart_id[63:56] <= ioctl_data[15:8];
				cart_pkg::ID_ADDR_FIRST + 25'd2:  cart_id[55:40] <= data_swap;
				cart_pkg::ID_ADDR_FIRST + 25'd4:  cart_id[39:24] <= data_swap;
				cart_pkg::ID_ADDR_FIRST + 25'd6:  cart_id[23:8]  <= data_swap;
				cart_pkg::ID_ADDR_LAST:           cart_id[7:0]   <= ioctl_data[7:0];
				default: ;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Lookup once the code is complete

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			dl_q      <= 1'b0;
			quirks    <= '0;
			gun_type  <= 1'b0;
			gun_delay <= cart_pkg::GUN_DELAY_DEFAULT;
		end else begin
			dl_q   <= cart_download;
			quirks <= quirk_base;

			if (word_stb && ioctl_addr == cart_pkg::ID_CHECK_ADDR) begin
				quirks <= quirk_base | quirk_of(cart_id);

				// Gun titles and their sensor offset
				case (cart_id)
					"MK-1533 ": {gun_type, gun_delay} <= {1'b0, 8'd100};
					"T-95096-": {gun_type, gun_delay} <= {1'b1, 8'd52}; // Two-gun type
					"T-95136-": {gun_type, gun_delay} <= {1'b1, 8'd30};
					"MK-1658 ": {gun_type, gun_delay} <= {1'b0, 8'd120};
					"T-081156": {gun_type, gun_delay} <= {1'b0, 8'd126};
					default: begin
						gun_type  <= 1'b0;
						gun_delay <= cart_pkg::GUN_DELAY_DEFAULT;
					end
				endcase
			end
		end
	end

endmodule

/* rtl/header_region_scan.sv */
`timescale 1ns/100ps

module header_region_scan (
	input  logic                clk_sys,
	input  logic                RESET,
	input  logic                cart_download,
	input  logic                ioctl_wr,
	input  cart_pkg::addr_t     ioctl_addr,
	input  cart_pkg::word_t     ioctl_data,
	output logic                hdr_j,
	output logic                hdr_u,
	output logic                hdr_e,
	output logic                hdr_ready
);

	logic       dl_q;
	logic       dl_rise;
	logic       dl_fall;
	logic [2:0] hit_lo;
	logic [2:0] hit_hi;
	logic [2:0] flags_base;

	// One region letter as {j, u, e}
	function automatic logic [2:0] classify(input logic [7:0] ch);
		logic [2:0] res;
		res = 3'b000;
		if (ch == "J")
			res = 3'b100;
		else if (ch == "U")
			res = 3'b010;
		else if (ch >= "0" && ch <= "Z")
			res = 3'b001; // Anything else printable counts as EU
		return res;
	endfunction

	assign dl_rise = cart_download & ~dl_q;
	assign dl_fall = ~cart_download & dl_q;

	assign hit_lo = classify(ioctl_data[7:0]);
	assign hit_hi = classify(ioctl_data[15:8]);

	// A new download starts from empty flags
	assign flags_base = dl_rise ? 3'b000 : {hdr_j, hdr_u, hdr_e};

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			dl_q      <= 1'b0;
			hdr_ready <= 1'b0;
			{hdr_j, hdr_u, hdr_e} <= 3'b000;
		end else begin
			dl_q <= cart_download;
			{hdr_j, hdr_u, hdr_e} <= flags_base;

			if (cart_download && ioctl_wr) begin
				if (ioctl_addr == cart_pkg::HDR_REGION_A)
					{hdr_j, hdr_u, hdr_e} <= flags_base | hit_lo | hit_hi;
				else if (ioctl_addr == cart_pkg::HDR_REGION_B)
					{hdr_j, hdr_u, hdr_e} <= flags_base | hit_lo; // Low byte only
				if (ioctl_addr == cart_pkg::HDR_DONE_ADDR)
					hdr_ready <= 1'b1;
			end

			if (dl_fall)
				hdr_ready <= 1'b0;
		end
	end

endmodule

/* rtl/rom_write_pacer.sv */
`timescale 1ns/100ps

module rom_write_pacer (
	input  logic                clk_sys,
	input  logic                RESET,
	input  logic                cart_download,
	input  logic                ioctl_wr,
	input  cart_pkg::addr_t     ioctl_addr,
	input  logic                mem_ack_a,
	input  logic                mem_ack_b,
	output logic                rom_wr,
	output logic                ioctl_wait,
	output cart_pkg::addr_t     rom_size
);

	cart_pkg::pacer_state_e state;
	logic dl_q;
	logic word_stb;
	logic acks_done;

	assign word_stb  = cart_download & ioctl_wr;
	// Both memories have copied the current request level
	assign acks_done = (mem_ack_a == rom_wr) && (mem_ack_b == rom_wr);

	assign ioctl_wait = (state == cart_pkg::PACE_WAIT);

	////////////////////////////////////////////////////////////////////////////
	// Toggle request and wait hold

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			state  <= cart_pkg::PACE_IDLE;
			rom_wr <= 1'b0;
		end else begin
			if (word_stb) begin
				rom_wr <= ~rom_wr; // New word for both memories
				state  <= cart_pkg::PACE_WAIT;
			end else begin
				case (state)
					cart_pkg::PACE_IDLE: state <= cart_pkg::PACE_IDLE;
					cart_pkg::PACE_WAIT: begin
						// Stay here as long as either memory lags
						if (acks_done)
							state <= cart_pkg::PACE_IDLE;
					end
					default: state <= cart_pkg::PACE_IDLE;
				endcase
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// ROM size at end of download

	always_ff @(posedge clk_sys) begin
		if (RESET)
			dl_q <= 1'b0;
		else
			dl_q <= cart_download;
	end

	always_ff @(posedge clk_sys) begin
		if (dl_q && !cart_download)
			rom_size <= ioctl_addr; // Last address the host sent
	end

endmodule

/* rtl/cart_pkg.sv */
package cart_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Widths

	localparam int ADDR_W      = 25;
	localparam int WORD_W      = 16;
	localparam int QUIRK_W     = 6;
	localparam int GUN_DELAY_W = 8;

	typedef logic [ADDR_W-1:0]      addr_t;      // Download byte address
	typedef logic [WORD_W-1:0]      word_t;      // Low byte comes first in file
	typedef logic [QUIRK_W-1:0]     quirk_t;
	typedef logic [GUN_DELAY_W-1:0] gun_delay_t;
	typedef logic [1:0]             region_t;

	// Region codes as the console core expects them
	localparam region_t REGION_JP = 2'd0;
	localparam region_t REGION_US = 2'd1;
	localparam region_t REGION_EU = 2'd2;

	// Write pacer states
	typedef enum logic {
		PACE_IDLE,
		PACE_WAIT
	} pacer_state_e;

	////////////////////////////////////////////////////////////////////////////
	// Cartridge header layout

	localparam addr_t HDR_REGION_A  = 25'h1F0; // Two region letters
	localparam addr_t HDR_REGION_B  = 25'h1F2; // Third letter in low byte
	localparam addr_t HDR_DONE_ADDR = 25'h200; // Header fully received

	// Product code words, byte swapped in the file
	localparam addr_t ID_ADDR_FIRST = 25'h182;
	localparam addr_t ID_ADDR_LAST  = 25'h18A;
	localparam addr_t ID_CHECK_ADDR = 25'h18C; // Code complete, run lookup

	// Bit positions in quirk_t
	localparam int Q_SRAM   = 0;
	localparam int Q_EEPROM = 1;
	localparam int Q_FIFO   = 2;
	localparam int Q_SVP    = 3;
	localparam int Q_FMBUSY = 4;
	localparam int Q_NORAM  = 5;

	localparam gun_delay_t GUN_DELAY_DEFAULT = 8'd44;

	////////////////////////////////////////////////////////////////////////////
	// Region settings

	localparam logic [1:0] MODE_FILE_EXT = 2'd1; // Region from file index
	localparam logic [1:0] MODE_HEADER   = 2'd2;
	localparam logic [1:0] MODE_DISABLED = 2'd3;

	localparam logic [1:0] PRIO_US_EU_JP = 2'd0;
	localparam logic [1:0] PRIO_EU_US_JP = 2'd1;
	localparam logic [1:0] PRIO_US_JP_EU = 2'd2;
	localparam logic [1:0] PRIO_JP_US_EU = 2'd3;

endpackage
